// File: pps_types_pkg.sv
// ----------------------------------------------------------------------
// PPS type definitions: source select codes and LMK sync FSM states
// ----------------------------------------------------------------------

package pps_types_pkg;

  // -------------------------------------------------------------------
  // PPS source selection
  // -------------------------------------------------------------------

  // Codes 2 and 3 both route the external PPS to the output
  // The second external code exists so that any 2-bit value is a legal select
  typedef enum logic [1:0] {
    PPS_SRC_INT_A   = 2'd0,
    PPS_SRC_INT_B   = 2'd1,
    PPS_SRC_EXT     = 2'd2,
    PPS_SRC_EXT_ALT = 2'd3
  } pps_src_e;

  // -------------------------------------------------------------------
  // LMK sync FSM
  // -------------------------------------------------------------------

  // IDLE waits for a request, ARMED waits for the next PPS rising edge
  // COUNT runs the programmed delay down to zero and fires the sync bit
  // DONE produces the one-cycle completion pulse
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ARMED = 2'd1,
    COUNT = 2'd2,
    DONE  = 2'd3
  } lmk_sync_state_e;

endpackage : pps_types_pkg

// File: pps_timing_pkg.sv
// ----------------------------------------------------------------------
// PPS timing constants: field widths, delay-line depth and duty cycle
// ----------------------------------------------------------------------

package pps_timing_pkg;

  // Width of the LMK sync delay count, in base_ref_clk cycles
  localparam int SYNC_DLY_W = 8;

  // Width of the tap select on the PPS alignment delay line
  localparam int ALIGN_DLY_W = 8;

  // One shift stage per tap value, so every select code reaches a stage
  localparam int ALIGN_DEPTH = 2 ** ALIGN_DLY_W;

  // High time of an internally generated PPS, in percent of its period
  // A quarter of the period keeps the pulse wide enough for slow samplers
  localparam int PPS_DUTY_PCT = 25;

endpackage : pps_timing_pkg

// File: pps_bus_if.sv
// ----------------------------------------------------------------------
// PPS bus between source selection, alignment delay and sync control
// ----------------------------------------------------------------------

`timescale 1ns/1ps

interface pps_bus_if
  import pps_types_pkg::*;
();

  // Source select, driven from the top level
  pps_src_e src_sel;

  // Registered PPS level after the source mux
  logic pps_level;

  // One-cycle strobe in the first cycle that pps_level is high
  logic pps_rise;

  // PPS shifted onto the aligned clock edge
  logic pps_aligned;

  // Source mux and edge detector
  modport src (
    input  src_sel,
    output pps_level,
    output pps_rise
  );

  // Programmable delay line
  modport align (
    input  pps_level,
    output pps_aligned
  );

  // LMK sync control only needs the edge strobe
  modport ctrl (
    input  pps_rise
  );

endinterface : pps_bus_if

// File: pps_generator.sv
// ----------------------------------------------------------------------
// Internal PPS generator with a fixed duty cycle for one clock frequency
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module pps_generator
  import pps_timing_pkg::*;
#(
  // Clock cycles per PPS period
  parameter int CLK_FREQ = 10_000_000,
  // High time in percent of the period
  parameter int DUTY_PCT = PPS_DUTY_PCT
) (
  input  logic base_ref_clk,
  input  logic brc_rst,
  output logic pps_o
);

  // Counter is wide enough to hold CLK_FREQ-1
  localparam int CNT_W = $clog2(CLK_FREQ);

  // Last count value before the counter wraps
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_FREQ - 1);

  // Number of cycles per period with the PPS high
  // Computed in 64 bits so large frequencies do not overflow the product
  localparam longint HIGH_CYCLES = longint'(CLK_FREQ) * DUTY_PCT / 100;
  localparam logic [CNT_W-1:0] CNT_HIGH = CNT_W'(HIGH_CYCLES);

  logic [CNT_W-1:0] period_cnt;

  // -------------------------------------------------------------------
  // Period counter and duty-cycle compare
  // -------------------------------------------------------------------

  // The compare uses the count before the increment
  // With the counter at zero after reset, the first edge drives pps_o high
  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      period_cnt <= '0;
      pps_o      <= 1'b0;
    end else begin
      if (period_cnt == CNT_LAST) begin
        period_cnt <= '0;
      end else begin
        period_cnt <= period_cnt + 1'b1;
      end
      // Output is registered so the PPS leaves the block glitch free
      pps_o <= (period_cnt < CNT_HIGH);
    end
  end

endmodule : pps_generator

// File: pps_source_select.sv
// ----------------------------------------------------------------------
// PPS source selection: external capture, source mux, rising edge strobe
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module pps_source_select
  import pps_types_pkg::*;
(
  input  logic      base_ref_clk,
  input  logic      brc_rst,
  // External PPS, asynchronous to base_ref_clk
  input  logic      pps_ext_i,
  // Internal PPS from generator A
  input  logic      pps_int_a_i,
  // Internal PPS from generator B
  input  logic      pps_int_b_i,
  pps_bus_if.src    bus
);

  // Two-stage synchronizer on the external PPS
  logic pps_ext_meta;
  logic pps_ext_sync;

  // Level of the mux register one cycle earlier
  logic pps_level_prev;

  // -------------------------------------------------------------------
  // External PPS capture
  // -------------------------------------------------------------------

  // The first flop may go metastable, the second gives it a full cycle
  // to resolve before the mux register samples it
  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      pps_ext_meta <= 1'b0;
      pps_ext_sync <= 1'b0;
    end else begin
      pps_ext_meta <= pps_ext_i;
      pps_ext_sync <= pps_ext_meta;
    end
  end

  // -------------------------------------------------------------------
  // Source mux register
  // -------------------------------------------------------------------

  // A select change lands asynchronously to the PPS, so a short or
  // stretched pulse can appear at the switch-over
  // Codes 2 and 3 both fall through to the external source
  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      bus.pps_level  <= 1'b0;
      pps_level_prev <= 1'b0;
    end else begin
      case (bus.src_sel)
        PPS_SRC_INT_A: begin
          bus.pps_level <= pps_int_a_i;
        end
        PPS_SRC_INT_B: begin
          bus.pps_level <= pps_int_b_i;
        end
        default: begin
          bus.pps_level <= pps_ext_sync;
        end
      endcase
      pps_level_prev <= bus.pps_level;
    end
  end

  // -------------------------------------------------------------------
  // Rising edge strobe
  // -------------------------------------------------------------------

  // High in the first cycle the mux output is high
  assign bus.pps_rise = bus.pps_level & ~pps_level_prev;

endmodule : pps_source_select

// File: pps_align_delay.sv
// ----------------------------------------------------------------------
// Programmable PPS delay line that moves the PPS onto the aligned edge
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module pps_align_delay
  import pps_timing_pkg::*;
(
  input  logic                   base_ref_clk,
  input  logic                   brc_rst,
  // Tap select, delay is align_delay_i plus two cycles
  input  logic [ALIGN_DLY_W-1:0] align_delay_i,
  pps_bus_if.align               bus
);

  // Stage 0 holds the newest sample of pps_level
  logic [ALIGN_DEPTH-1:0] pps_shift;

  // -------------------------------------------------------------------
  // Shift register and tap register
  // -------------------------------------------------------------------

  // The delay has to cover the path from PPS to the LMK sync output,
  // the LMK latency from sync to the aligned edge and the sync delay
  // The final register adds one cycle on top of the shift stage
  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      pps_shift       <= '0;
      bus.pps_aligned <= 1'b0;
    end else begin
      pps_shift       <= {pps_shift[ALIGN_DEPTH-2:0], bus.pps_level};
      bus.pps_aligned <= pps_shift[align_delay_i];
    end
  end

endmodule : pps_align_delay

// File: lmk_sync_ctrl.sv
// ----------------------------------------------------------------------
// LMK sync control: request handshake and PPS-timed sync pulse FSM
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module lmk_sync_ctrl
  import pps_types_pkg::*;
  import pps_timing_pkg::*;
(
  input  logic                  base_ref_clk,
  input  logic                  brc_rst,
  // Sync request handshake
  input  logic                  sync_req_valid_i,
  output logic                  sync_req_ready_o,
  // Cycles from the sampled PPS edge to the sync bit, minus two
  input  logic [SYNC_DLY_W-1:0] sync_delay_i,
  pps_bus_if.ctrl               bus,
  // Sync to the LMK, launched on the falling clock edge
  output logic                  lmk_sync_o,
  // One-cycle completion pulse
  output logic                  sync_done_o
);

  lmk_sync_state_e       state_q;
  logic [SYNC_DLY_W-1:0] delay_q;
  logic [SYNC_DLY_W-1:0] delay_cnt;
  logic                  sync_int;
  logic                  req_accept;

  // -------------------------------------------------------------------
  // Request handshake
  // -------------------------------------------------------------------

  // Ready only while idle and no done pulse is being shown
  // A request made during a sync waits here, which is the only back-pressure
  assign sync_req_ready_o = (state_q == IDLE) && !sync_done_o;
  assign req_accept       = sync_req_valid_i && sync_req_ready_o;

  // -------------------------------------------------------------------
  // Sync FSM
  // -------------------------------------------------------------------

  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      state_q     <= IDLE;
      delay_q     <= '0;
      delay_cnt   <= '0;
      sync_int    <= 1'b0;
      sync_done_o <= 1'b0;
    end else begin
      // Sync bit and done are single-cycle pulses
      sync_int    <= 1'b0;
      sync_done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          // Delay is captured in the same cycle as the handshake
          if (req_accept) begin
            delay_q <= sync_delay_i;
            state_q <= ARMED;
          end
        end

        ARMED: begin
          // Counter starts from the captured delay on the PPS edge
          if (bus.pps_rise) begin
            delay_cnt <= delay_q;
            state_q   <= COUNT;
          end
        end

        COUNT: begin
          // Zero delay still takes one pass through this state
          if (delay_cnt == '0) begin
            sync_int <= 1'b1;
            state_q  <= DONE;
          end else begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end

        DONE: begin
          // Done follows the sync bit and the FSM is idle again with it
          sync_done_o <= 1'b1;
          state_q     <= IDLE;
        end

        default: begin
          // Recover from an undefined state
          state_q <= IDLE;
        end
      endcase
    end
  end

  // -------------------------------------------------------------------
  // LMK sync output
  // -------------------------------------------------------------------

  // Launching on the falling edge gives half a cycle of hold margin at the LMK
  always_ff @(negedge base_ref_clk) begin
    if (brc_rst) begin
      lmk_sync_o <= 1'b0;
    end else begin
      lmk_sync_o <= sync_int;
    end
  end

endmodule : lmk_sync_ctrl

// File: pps_sync_top.sv
// ----------------------------------------------------------------------
// PPS handling and LMK sync generation in the base reference clock domain
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module pps_sync_top
  import pps_types_pkg::*;
  import pps_timing_pkg::*;
#(
  // Cycles per PPS period for each supported reference rate
  parameter int INT_A_FREQ = 10_000_000,
  parameter int INT_B_FREQ = 25_000_000
) (
  input  logic                   base_ref_clk,
  input  logic                   brc_rst,
  input  logic                   pps_i,
  input  logic [1:0]             pps_select_i,
  input  logic [ALIGN_DLY_W-1:0] align_delay_i,
  input  logic                   sync_req_valid_i,
  output logic                   sync_req_ready_o,
  input  logic [SYNC_DLY_W-1:0]  sync_delay_i,
  output logic                   pps_o,
  output logic                   pps_aligned_o,
  output logic                   lmk_sync_o,
  output logic                   sync_done_o
);

  logic pps_int_a;
  logic pps_int_b;

  pps_bus_if pps_bus ();

  // -------------------------------------------------------------------
  // PPS generation and source selection
  // -------------------------------------------------------------------

  // Both generators run all the time, only one is selected
  pps_generator #(
    .CLK_FREQ (INT_A_FREQ),
    .DUTY_PCT (PPS_DUTY_PCT)
  ) pps_gen_a (
    .base_ref_clk (base_ref_clk),
    .brc_rst      (brc_rst),
    .pps_o        (pps_int_a)
  );

  pps_generator #(
    .CLK_FREQ (INT_B_FREQ),
    .DUTY_PCT (PPS_DUTY_PCT)
  ) pps_gen_b (
    .base_ref_clk (base_ref_clk),
    .brc_rst      (brc_rst),
    .pps_o        (pps_int_b)
  );

  assign pps_bus.src_sel = pps_src_e'(pps_select_i);

  pps_source_select u_source_select (
    .base_ref_clk (base_ref_clk),
    .brc_rst      (brc_rst),
    .pps_ext_i    (pps_i),
    .pps_int_a_i  (pps_int_a),
    .pps_int_b_i  (pps_int_b),
    .bus          (pps_bus.src)
  );

  // -------------------------------------------------------------------
  // Alignment delay and LMK sync
  // -------------------------------------------------------------------

  pps_align_delay u_align_delay (
    .base_ref_clk  (base_ref_clk),
    .brc_rst       (brc_rst),
    .align_delay_i (align_delay_i),
    .bus           (pps_bus.align)
  );

  lmk_sync_ctrl u_sync_ctrl (
    .base_ref_clk     (base_ref_clk),
    .brc_rst          (brc_rst),
    .sync_req_valid_i (sync_req_valid_i),
    .sync_req_ready_o (sync_req_ready_o),
    .sync_delay_i     (sync_delay_i),
    .bus              (pps_bus.ctrl),
    .lmk_sync_o       (lmk_sync_o),
    .sync_done_o      (sync_done_o)
  );

  // Selected and aligned PPS go straight out, no extra registers
  assign pps_o         = pps_bus.pps_level;
  assign pps_aligned_o = pps_bus.pps_aligned;

endmodule : pps_sync_top

// File: pps_sync_assert.sv
// ----------------------------------------------------------------------
// Concurrent checks on the LMK sync FSM and its request handshake
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module pps_sync_assert
  import pps_types_pkg::*;
(
  input logic            base_ref_clk,
  input logic            brc_rst,
  input lmk_sync_state_e state_q,
  input logic            sync_req_valid_i,
  input logic            sync_req_ready_o,
  input logic            sync_int,
  input logic            lmk_sync_o,
  input logic            sync_done_o
);

  // Number of assertion failures so far
  int fail_count = 0;

  // Ready is shown only in IDLE, and not in the cycle after the sync bit
  ready_in_idle: assert property (@(posedge base_ref_clk) disable iff (brc_rst)
    sync_req_ready_o == (state_q == IDLE && !$past(sync_int)))
    else begin
      fail_count++;
      $error("sync ready does not match the IDLE state");
    end

  // The LMK sync pulse lasts a single cycle
  lmk_single_cycle: assert property (@(posedge base_ref_clk) disable iff (brc_rst)
    lmk_sync_o |=> !lmk_sync_o)
    else begin
      fail_count++;
      $error("lmk_sync_o high on two consecutive edges");
    end

  // Done comes one cycle after the internal sync bit and never on its own
  done_after_sync: assert property (@(posedge base_ref_clk) disable iff (brc_rst)
    sync_int |=> sync_done_o)
    else begin
      fail_count++;
      $error("sync_done_o missing after the sync bit");
    end
  done_has_sync: assert property (@(posedge base_ref_clk) disable iff (brc_rst)
    sync_done_o |-> $past(sync_int))
    else begin
      fail_count++;
      $error("sync_done_o without a preceding sync bit");
    end

  // Requests are only taken while idle, and an accepted request arms the FSM
  accept_in_idle: assert property (@(posedge base_ref_clk) disable iff (brc_rst)
    (sync_req_valid_i && sync_req_ready_o) |-> state_q == IDLE ##1 state_q == ARMED)
    else begin
      fail_count++;
      $error("sync request accepted outside IDLE or did not arm the FSM");
    end

endmodule : pps_sync_assert

// File: tb_pps_sync_top.sv
// ----------------------------------------------------------------------
// Testbench for the PPS and LMK sync block against a cycle-based model
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_pps_sync_top
  import pps_types_pkg::*;
  import pps_timing_pkg::*;
();

  // Short PPS periods and their 25 percent high times
  localparam int FREQ_A = 40;
  localparam int FREQ_B = 100;
  localparam int HIGH_A = FREQ_A * 25 / 100;
  localparam int HIGH_B = FREQ_B * 25 / 100;
  localparam int WAIT_LIMIT = 700;

  logic                   base_ref_clk;
  logic                   brc_rst;
  logic                   pps_i;
  logic [1:0]             pps_select_i;
  logic [ALIGN_DLY_W-1:0] align_delay_i;
  logic                   sync_req_valid_i;
  logic                   sync_req_ready_o;
  logic [SYNC_DLY_W-1:0]  sync_delay_i;
  logic                   pps_o;
  logic                   pps_aligned_o;
  logic                   lmk_sync_o;
  logic                   sync_done_o;

  // Model state, one step per rising edge after reset
  int     cyc;
  int     cnt_a;
  int     cnt_b;
  logic   gen_a;
  logic   gen_b;
  logic   ext_meta;
  logic   ext_sync;
  logic   exp_pps;
  logic   obs_prev;
  logic   hist [0:511];
  logic   m_ready;
  logic   m_armed;
  int     m_delay;
  int     sync_edge;
  int     done_seen;
  int     err_count;
  int     check_count;
  int     test_count;
  integer seed;

  pps_sync_top #(
    .INT_A_FREQ (FREQ_A),
    .INT_B_FREQ (FREQ_B)
  ) dut (
    .base_ref_clk     (base_ref_clk),
    .brc_rst          (brc_rst),
    .pps_i            (pps_i),
    .pps_select_i     (pps_select_i),
    .align_delay_i    (align_delay_i),
    .sync_req_valid_i (sync_req_valid_i),
    .sync_req_ready_o (sync_req_ready_o),
    .sync_delay_i     (sync_delay_i),
    .pps_o            (pps_o),
    .pps_aligned_o    (pps_aligned_o),
    .lmk_sync_o       (lmk_sync_o),
    .sync_done_o      (sync_done_o)
  );

  bind lmk_sync_ctrl pps_sync_assert u_sync_assert (
    .base_ref_clk     (base_ref_clk),
    .brc_rst          (brc_rst),
    .state_q          (state_q),
    .sync_req_valid_i (sync_req_valid_i),
    .sync_req_ready_o (sync_req_ready_o),
    .sync_int         (sync_int),
    .lmk_sync_o       (lmk_sync_o),
    .sync_done_o      (sync_done_o)
  );

  initial begin
    base_ref_clk = 1'b0;
    forever #10 base_ref_clk = ~base_ref_clk;
  end

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    check_count++;
    assert (act_v === exp_v) else begin
      $display("[ERROR] %s expected %h actual %h at cycle %0d", name, exp_v, act_v, cyc);
      err_count++;
    end
  endtask

  task automatic check_int(input string name, input int exp_v, input int act_v);
    check_count++;
    assert (act_v == exp_v) else begin
      $display("[ERROR] %s expected %h actual %h at cycle %0d", name, exp_v, act_v, cyc);
      err_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s at cycle %0d", what, cyc);
    err_count++;
  endtask

  task automatic end_test(input string name, input int base_err);
    test_count++;
    $display("test %0d %s: %s", test_count, name, (err_count == base_err) ? "ok" : "errors");
  endtask

  // -------------------------------------------------------------------
  // Reference model and per-edge compare
  // -------------------------------------------------------------------

  // Sampled 1 ns after the rising edge, where registered outputs have settled
  // and lmk_sync_o still holds the value launched at the previous falling edge
  initial begin : model_and_check
    logic next_pps;
    int   tap;
    forever begin
      @(posedge base_ref_clk);
      #1;
      if (brc_rst) begin
        cyc = 0;
        cnt_a = 0;
        cnt_b = 0;
        gen_a = 1'b0;
        gen_b = 1'b0;
        ext_meta = 1'b0;
        ext_sync = 1'b0;
        exp_pps = 1'b0;
        obs_prev = 1'b0;
        m_ready = 1'b1;
        m_armed = 1'b0;
        sync_edge = -10;
      end else begin
        cyc++;
        // Mux register loads the source values from the previous edge
        case (pps_select_i)
          PPS_SRC_INT_A: next_pps = gen_a;
          PPS_SRC_INT_B: next_pps = gen_b;
          default: next_pps = ext_sync;
        endcase
        ext_sync = ext_meta;
        ext_meta = pps_i;
        gen_a = (cnt_a < HIGH_A);
        gen_b = (cnt_b < HIGH_B);
        cnt_a = (cnt_a + 1) % FREQ_A;
        cnt_b = (cnt_b + 1) % FREQ_B;
        exp_pps = next_pps;
        hist[cyc % 512] = next_pps;
        // Aligned output is the PPS from align + 2 edges back
        tap = cyc - 2 - align_delay_i;
        // Handshake first, so a PPS rise on the accept edge still arms
        if (sync_req_valid_i && m_ready) begin
          m_ready = 1'b0;
          m_armed = 1'b1;
          m_delay = sync_delay_i;
        end
        if (m_armed && pps_o && !obs_prev) begin
          m_armed = 1'b0;
          sync_edge = cyc + m_delay + 2;
        end
        if (cyc == sync_edge + 2) m_ready = 1'b1;
        check_bit("pps_o", exp_pps, pps_o);
        check_bit("pps_aligned_o", (tap <= 0) ? 1'b0 : hist[tap % 512], pps_aligned_o);
        check_bit("sync_req_ready_o", m_ready, sync_req_ready_o);
        check_bit("lmk_sync_o", cyc == sync_edge + 1, lmk_sync_o);
        check_bit("sync_done_o", cyc == sync_edge + 1, sync_done_o);
        if (sync_done_o) done_seen++;
        obs_prev = pps_o;
      end
    end
  end

  // -------------------------------------------------------------------
  // Stimulus helpers
  // -------------------------------------------------------------------

  // Counts falling edges until pps_o reaches the given level
  task automatic count_until_pps(input logic lvl, output int cycles);
    cycles = 0;
    while (pps_o !== lvl && cycles < 300) begin
      @(negedge base_ref_clk);
      cycles++;
    end
    if (cycles >= 300) report_timeout("pps_o did not change level within 300 cycles");
  endtask

  task automatic measure_pps(input int exp_period, input int exp_high, input logic check);
    int skip;
    int high_len;
    int low_len;
    count_until_pps(1'b0, skip);
    count_until_pps(1'b1, skip);
    count_until_pps(1'b0, high_len);
    count_until_pps(1'b1, low_len);
    if (check) begin
      check_int("pps_o high cycles", exp_high, high_len);
      check_int("pps_o period", exp_period, high_len + low_len);
    end
  endtask

  // Holds valid and delay until ready is seen, then drops valid
  task automatic send_request(input logic [SYNC_DLY_W-1:0] d);
    int n;
    @(negedge base_ref_clk);
    sync_req_valid_i <= 1'b1;
    sync_delay_i     <= d;
    n = 0;
    while (!sync_req_ready_o && n < WAIT_LIMIT) begin
      @(negedge base_ref_clk);
      n++;
    end
    if (n >= WAIT_LIMIT) report_timeout("sync request was never accepted");
    @(negedge base_ref_clk);
    sync_req_valid_i <= 1'b0;
  endtask

  task automatic wait_done_count(input int target);
    int n;
    n = 0;
    while (done_seen < target && n < WAIT_LIMIT) begin
      @(negedge base_ref_clk);
      n++;
    end
    if (n >= WAIT_LIMIT) report_timeout("sync_done_o pulse did not arrive");
  endtask

  // -------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------

  initial begin : stimulus
    int base_err;
    int target;
    logic [SYNC_DLY_W-1:0] delays [0:4];
    seed = 32'h20cc608a;
    brc_rst = 1'b1;
    pps_i = 1'b0;
    pps_select_i = 2'd0;
    align_delay_i = '0;
    sync_req_valid_i = 1'b0;
    sync_delay_i = '0;
    done_seen = 0;
    err_count = 0;
    check_count = 0;
    test_count = 0;
    repeat (8) @(negedge base_ref_clk);
    brc_rst <= 1'b0;

    // Idle outputs after reset, then generator A on select 0
    base_err = err_count;
    @(negedge base_ref_clk);
    check_bit("pps_o", 1'b0, pps_o);
    check_bit("pps_aligned_o", 1'b0, pps_aligned_o);
    check_bit("lmk_sync_o", 1'b0, lmk_sync_o);
    check_bit("sync_done_o", 1'b0, sync_done_o);
    check_bit("sync_req_ready_o", 1'b1, sync_req_ready_o);
    measure_pps(FREQ_A, HIGH_A, 1'b1);
    end_test("reset and internal A", base_err);

    // Generator B, the first period after the switch may be glitched
    base_err = err_count;
    pps_select_i <= 2'd1;
    measure_pps(FREQ_B, HIGH_B, 1'b0);
    measure_pps(FREQ_B, HIGH_B, 1'b1);
    end_test("internal B", base_err);

    // External pulse train with random toggles
    base_err = err_count;
    pps_select_i <= 2'd2 + 2'($random(seed) & 1);
    repeat (300) begin
      @(negedge base_ref_clk);
      if (($random(seed) & 7) == 0) pps_i <= ~pps_i;
    end
    pps_i <= 1'b0;
    end_test("external PPS", base_err);

    // Sync requests, the extreme delays first
    base_err = err_count;
    pps_select_i <= 2'd0;
    delays[0] = 8'd0;
    delays[1] = 8'd255;
    for (int i = 2; i < 5; i++) delays[i] = 8'($random(seed));
    for (int i = 0; i < 5; i++) begin
      target = done_seen + 1;
      send_request(delays[i]);
      wait_done_count(target);
    end
    end_test("sync requests", base_err);

    // Random tap settings, each held past one full PPS period
    base_err = err_count;
    for (int i = 0; i < 4; i++) begin
      @(negedge base_ref_clk);
      align_delay_i <= (i == 0) ? 8'd255 : 8'($random(seed));
      repeat (300) @(negedge base_ref_clk);
    end
    end_test("align delay", base_err);

    // Second request held while the first one is still running
    base_err = err_count;
    target = done_seen + 2;
    send_request(8'($random(seed)));
    send_request(8'($random(seed)));
    check_int("done pulses before second accept", target - 1, done_seen);
    wait_done_count(target);
    end_test("back-pressure", base_err);

    repeat (4) @(negedge base_ref_clk);
    // Failures of the bound FSM assertions add to the error total
    err_count += dut.u_sync_ctrl.u_sync_assert.fail_count;
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : tb_pps_sync_top

// File: all.f
pps_types_pkg.sv
pps_timing_pkg.sv
pps_bus_if.sv
pps_generator.sv
pps_source_select.sv
pps_align_delay.sv
lmk_sync_ctrl.sv
pps_sync_top.sv
pps_sync_assert.sv
tb_pps_sync_top.sv
